// File: design/armPkg.sv
// Widths, encodings, instruction word views and control bundles shared by the ARM core
package armPkg;
	localparam int wordWidth = 32;
	localparam int regAddrWidth = 4;
	localparam int pcRegIndex = 15;

	typedef logic [wordWidth-1:0] word_t;
	typedef logic [regAddrWidth-1:0] regAddr_t;

	localparam logic [3:0] mulMarker = 4'b1001; // Bits 7:4 of a MUL

	// resultSrc and aluSrcB selections
	localparam logic [1:0] resultAluOut = 2'b00;
	localparam logic [1:0] resultData = 2'b01;
	localparam logic [1:0] resultAluResult = 2'b10;
	localparam logic [1:0] srcBReg = 2'b00;
	localparam logic [1:0] srcBImm = 2'b01;
	localparam logic [1:0] srcBFour = 2'b10;

	typedef enum logic [2:0] {
		aluAdd = 3'b000,
		aluSub = 3'b001,
		aluAnd = 3'b010,
		aluOrr = 3'b011,
		aluEor = 3'b100,
		aluMul = 3'b101
	} aluOp_e;

	typedef enum logic [3:0] {
		fetchState, decodeState, memAdrState, memReadState, memWriteBackState,
		memWriteState, executeRegState, executeImmState, aluWriteBackState, branchState
	} fsmState_e;

	typedef enum logic [1:0] {
		opDataProc = 2'b00,
		opMemory = 2'b01,
		opBranch = 2'b10
	} opClass_e;

	typedef enum logic [3:0] {
		eq, ne, cs, cc, mi, pl, vs, vc, hi, ls, ge, lt, gt, le, al
	} condCode_e;

	typedef struct packed {
		condCode_e cond;
		opClass_e op;
		logic immediate;
		logic [3:0] cmd;
		logic s;
		regAddr_t rn;
		regAddr_t rd;
		logic [11:0] operand2;
	} dataProcView_t;

	typedef struct packed {
		condCode_e cond;
		opClass_e op;
		logic [4:0] addrMode; // I, P, U, B, W
		logic load;
		regAddr_t rn;
		regAddr_t rd;
		logic [11:0] offset12;
	} memoryView_t;

	typedef struct packed {
		condCode_e cond;
		opClass_e op;
		logic [1:0] funct;
		logic [23:0] offset24;
	} branchView_t;

	typedef struct packed {
		condCode_e cond;
		opClass_e op;
		logic [5:0] funct;
		regAddr_t rd;
		regAddr_t ra;
		regAddr_t rs;
		logic [3:0] marker;
		regAddr_t rm;
	} multiplyView_t;

	typedef union packed {
		dataProcView_t dataProcView;
		memoryView_t memoryView;
		branchView_t branchView;
		multiplyView_t multiplyView;
	} instr_u;

	typedef struct packed {
		logic nextPc;
		logic branch;
		logic memW;
		logic regW;
		logic irWrite;
		logic adrSrc;
		logic [1:0] resultSrc;
		logic aluSrcA;
		logic [1:0] aluSrcB;
		logic aluOpEnable;
	} fsmCtrl_t;

	typedef struct packed {
		logic pcWrite;
		logic regWrite;
		logic irWrite;
		logic adrSrc;
		logic [1:0] resultSrc;
		logic aluSrcA;
		logic [1:0] aluSrcB;
		opClass_e immSrc;
		logic [1:0] regSrc;
		logic multiplyFormat;
		aluOp_e aluControl;
	} dpCtrl_t;

	typedef struct packed {
		word_t adr;
		word_t writeData;
		logic write;
	} memReq_t;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} flags_t;
endpackage

// File: design/alu.sv
// Add, subtract, AND, ORR, EOR and 32-bit multiply with NZCV
`timescale 1ns/100ps
module alu
	import armPkg::*;
(
	input word_t a,
	input word_t b,
	input aluOp_e control,
	output word_t result,
	output flags_t flags
);
	logic subtract;
	logic arithmetic;
	word_t bInv;
	logic [wordWidth:0] sum;
	logic overflow;

	assign subtract = (control == aluSub);
	assign arithmetic = (control == aluAdd) || subtract;
	assign bInv = subtract ? ~b : b;
	assign sum = {1'b0, a} + {1'b0, bInv} + {{wordWidth{1'b0}}, subtract}; // a - b = a + ~b + 1

	always_comb begin
		case (control)
			aluAdd: result = sum[wordWidth-1:0];
			aluSub: result = sum[wordWidth-1:0];
			aluAnd: result = a & b;
			aluOrr: result = a | b;
			aluEor: result = a ^ b;
			aluMul: result = a * b; // Low word only
			default: result = sum[wordWidth-1:0];
		endcase
	end

	// Same-sign operands giving a result of the other sign
	assign overflow = (a[wordWidth-1] ~^ bInv[wordWidth-1])
		&& (a[wordWidth-1] ^ sum[wordWidth-1]);

	assign flags = '{
		n: result[wordWidth-1],
		z: (result == '0),
		c: arithmetic && sum[wordWidth],
		v: arithmetic && overflow
	};
endmodule

// File: design/regFile.sv
// Fifteen general registers with R15 supplied by the datapath
`timescale 1ns/100ps
module regFile
	import armPkg::*;
(
	input logic clk,
	input logic writeEnable,
	input regAddr_t readAddr1,
	input regAddr_t readAddr2,
	input regAddr_t writeAddr,
	input word_t writeData,
	input word_t pcPlus8,
	output word_t readData1,
	output word_t readData2
);
	word_t regs [0:pcRegIndex-1];

	always_ff @(posedge clk) begin
		if (writeEnable)
			regs[writeAddr] <= writeData;
	end

	assign readData1 = (readAddr1 == regAddr_t'(pcRegIndex)) ? pcPlus8 : regs[readAddr1];
	assign readData2 = (readAddr2 == regAddr_t'(pcRegIndex)) ? pcPlus8 : regs[readAddr2];

	// Writes to R15 must have been turned into PC writes upstream
	noPcWrite: assert property (@(posedge clk)
		writeEnable |-> writeAddr != regAddr_t'(pcRegIndex))
		else $error("Register file write aimed at R15");
endmodule

// File: design/datapath.sv
// PC, instruction and data registers, operand muxes, extension and result select
`timescale 1ns/100ps
module datapath
	import armPkg::*;
#(
	parameter word_t resetAddress = '0
) (
	input logic clk,
	input logic reset,
	input dpCtrl_t ctrl,
	input word_t readData,
	output instr_u instr,
	output flags_t aluFlags,
	output word_t adr,
	output word_t writeData
);
	word_t pc;
	instr_u instrReg;
	word_t data;
	word_t aReg;
	word_t writeDataReg;
	word_t aluOut;
	word_t aluResult;
	word_t result;
	word_t extImm;
	word_t srcA;
	word_t srcB;
	word_t readData1;
	word_t readData2;
	regAddr_t readAddr1;
	regAddr_t readAddr2;
	regAddr_t writeAddr;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= resetAddress;
			instrReg <= '0;
		end else begin
			if (ctrl.pcWrite)
				pc <= result;
			if (ctrl.irWrite)
				instrReg <= readData;
		end
	end

	// Non-architectural registers between cycles
	always_ff @(posedge clk) begin
		data <= readData;
		aReg <= readData1;
		writeDataReg <= readData2;
		aluOut <= aluResult;
	end

	assign adr = ctrl.adrSrc ? result : pc;
	assign instr = instrReg;
	assign writeData = writeDataReg;

	always_comb begin
		if (ctrl.regSrc[0])
			readAddr1 = regAddr_t'(pcRegIndex); // Branch base is PC + 8
		else if (ctrl.multiplyFormat)
			readAddr1 = instrReg.multiplyView.rm;
		else
			readAddr1 = instrReg.dataProcView.rn;

		if (ctrl.regSrc[1])
			readAddr2 = instrReg.memoryView.rd; // Store data
		else if (ctrl.multiplyFormat)
			readAddr2 = instrReg.multiplyView.rs;
		else
			readAddr2 = instrReg.dataProcView.operand2[3:0];

		writeAddr = ctrl.multiplyFormat ? instrReg.multiplyView.rd : instrReg.dataProcView.rd;
	end

	regFile regs (
		.clk(clk),
		.writeEnable(ctrl.regWrite),
		.readAddr1(readAddr1),
		.readAddr2(readAddr2),
		.writeAddr(writeAddr),
		.writeData(result),
		.pcPlus8(result), // Holds PC + 4 during decode
		.readData1(readData1),
		.readData2(readData2)
	);

	always_comb begin
		case (ctrl.immSrc)
			opDataProc: extImm = {24'b0, instrReg.dataProcView.operand2[7:0]};
			opMemory: extImm = {20'b0, instrReg.memoryView.offset12};
			default: extImm = {{6{instrReg.branchView.offset24[23]}},
				instrReg.branchView.offset24, 2'b00};
		endcase
	end

	assign srcA = ctrl.aluSrcA ? pc : aReg;

	always_comb begin
		case (ctrl.aluSrcB)
			srcBReg: srcB = writeDataReg;
			srcBImm: srcB = extImm;
			srcBFour: srcB = word_t'(4);
			default: srcB = writeDataReg;
		endcase
	end

	alu alu (
		.a(srcA),
		.b(srcB),
		.control(ctrl.aluControl),
		.result(aluResult),
		.flags(aluFlags)
	);

	always_comb begin
		case (ctrl.resultSrc)
			resultAluOut: result = aluOut;
			resultData: result = data;
			resultAluResult: result = aluResult;
			default: result = aluOut;
		endcase
	end

	// Loads and stores address whole words only
	dataAligned: assert property (@(posedge clk) disable iff (reset)
		ctrl.adrSrc |-> adr[1:0] == 2'b00)
		else $error("Data access at unaligned address %h", adr);
endmodule

// File: design/mainFsm.sv
// Multicycle state register, next-state logic and per-state control patterns
`timescale 1ns/100ps
module mainFsm
	import armPkg::*;
(
	input logic clk,
	input logic reset,
	input opClass_e opClass,
	input logic immediateOperand,
	input logic load,
	output fsmCtrl_t ctrl
);
	fsmState_e state;
	fsmState_e nextState;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			state <= fetchState;
		else
			state <= nextState;
	end

	always_comb begin
		case (state)
			fetchState: nextState = decodeState;
			decodeState: begin
				case (opClass)
					opDataProc: nextState = immediateOperand ? executeImmState : executeRegState;
					opMemory: nextState = memAdrState;
					opBranch: nextState = branchState;
					default: nextState = fetchState; // Unused class, skip it
				endcase
			end
			memAdrState: nextState = load ? memReadState : memWriteState;
			memReadState: nextState = memWriteBackState;
			executeRegState: nextState = aluWriteBackState;
			executeImmState: nextState = aluWriteBackState;
			default: nextState = fetchState; // Write-back, store and branch all end here
		endcase
	end

	// Bit order nextPc branch memW regW | irWrite adrSrc resultSrc[1:0]
	// | aluSrcA aluSrcB[1:0] aluOpEnable
	always_comb begin
		case (state)
			fetchState: ctrl = 12'b1000_1010_1100;        // IR load, PC += 4
			decodeState: ctrl = 12'b0000_0010_1100;       // PC + 4 feeds R15
			memAdrState: ctrl = 12'b0000_0000_0010;       // Rn + offset
			memReadState: ctrl = 12'b0000_0100_0000;
			memWriteBackState: ctrl = 12'b0001_0001_0000;
			memWriteState: ctrl = 12'b0010_0100_0000;
			executeRegState: ctrl = 12'b0000_0000_0001;
			executeImmState: ctrl = 12'b0000_0000_0011;
			aluWriteBackState: ctrl = 12'b0001_0000_0000;
			branchState: ctrl = 12'b0100_0010_0010;       // Target straight from ALU
			default: ctrl = '0;
		endcase
	end

	// Only the ten defined states may ever be reached
	stateKnown: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(state) && state inside {[fetchState:branchState]})
		else $error("FSM state %0d is not a defined state", state);
endmodule

// File: design/instrDecoder.sv
// ALU decode, flag-write select, PC-write request and operand routing
`timescale 1ns/100ps
module instrDecoder
	import armPkg::*;
(
	input logic clk,
	input logic reset,
	input instr_u instr,
	output dpCtrl_t dpDecode,
	output logic [1:0] flagWrite,
	output logic pcSrcRequest,
	output logic regWriteRequest,
	output logic memWriteRequest,
	output logic nextPc
);
	fsmCtrl_t ctrl;
	opClass_e opClass;
	logic multiplyFormat;
	logic destIsPc;
	regAddr_t destAddr;
	aluOp_e aluControl;

	assign opClass = instr.dataProcView.op;

	mainFsm fsm (
		.clk(clk),
		.reset(reset),
		.opClass(opClass),
		.immediateOperand(instr.dataProcView.immediate),
		.load(instr.memoryView.load),
		.ctrl(ctrl)
	);

	// MUL hides inside the register form of the data-processing class
	assign multiplyFormat = (opClass == opDataProc) && !instr.dataProcView.immediate
		&& (instr.multiplyView.marker == mulMarker);
	assign destAddr = multiplyFormat ? instr.multiplyView.rd : instr.dataProcView.rd;
	assign destIsPc = (destAddr == regAddr_t'(pcRegIndex));

	always_comb begin
		aluControl = aluAdd; // Address and PC arithmetic
		flagWrite = 2'b00;
		if (ctrl.aluOpEnable) begin
			if (multiplyFormat)
				aluControl = aluMul;
			else begin
				case (instr.dataProcView.cmd)
					4'b0100: aluControl = aluAdd;
					4'b0010: aluControl = aluSub;
					4'b0000: aluControl = aluAnd;
					4'b1100: aluControl = aluOrr;
					4'b0001: aluControl = aluEor;
					default: aluControl = aluAdd;
				endcase
			end
			flagWrite[1] = instr.dataProcView.s; // NZ
			flagWrite[0] = instr.dataProcView.s
				&& (aluControl == aluAdd || aluControl == aluSub); // CV from adder only
		end
	end

	// A write to R15 goes to the PC instead of the register file
	assign pcSrcRequest = ctrl.branch || (ctrl.regW && destIsPc);
	assign regWriteRequest = ctrl.regW && !destIsPc;
	assign memWriteRequest = ctrl.memW;
	assign nextPc = ctrl.nextPc;

	assign dpDecode = '{
		pcWrite: 1'b0,
		regWrite: 1'b0,
		irWrite: ctrl.irWrite,
		adrSrc: ctrl.adrSrc,
		resultSrc: ctrl.resultSrc,
		aluSrcA: ctrl.aluSrcA,
		aluSrcB: ctrl.aluSrcB,
		immSrc: opClass,
		regSrc: {opClass == opMemory, opClass == opBranch},
		multiplyFormat: multiplyFormat,
		aluControl: aluControl
	};
endmodule

// File: design/condLogic.sv
// NZ and CV flag registers, condition check and write-enable gating
`timescale 1ns/100ps
module condLogic
	import armPkg::*;
(
	input logic clk,
	input logic reset,
	input condCode_e cond,
	input flags_t aluFlags,
	input logic [1:0] flagWrite,
	input logic pcSrcRequest,
	input logic regWriteRequest,
	input logic memWriteRequest,
	input logic nextPc,
	output logic pcWrite,
	output logic regWrite,
	output logic memWrite
);
	logic [1:0] nzFlags;
	logic [1:0] cvFlags;
	flags_t heldFlags;
	logic [1:0] flagEnable;
	logic condEx;
	logic condHeld;
	logic signedGe;

	assign flagEnable = flagWrite & {2{condHeld}};

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			nzFlags <= 2'b00;
			cvFlags <= 2'b00;
			condHeld <= 1'b0;
		end else begin
			condHeld <= condEx; // Check made in decode, used from execute on
			if (flagEnable[1])
				nzFlags <= {aluFlags.n, aluFlags.z};
			if (flagEnable[0])
				cvFlags <= {aluFlags.c, aluFlags.v};
		end
	end

	assign heldFlags = {nzFlags, cvFlags};
	assign signedGe = (heldFlags.n == heldFlags.v);

	always_comb begin
		case (cond)
			eq: condEx = heldFlags.z;
			ne: condEx = !heldFlags.z;
			cs: condEx = heldFlags.c;
			cc: condEx = !heldFlags.c;
			mi: condEx = heldFlags.n;
			pl: condEx = !heldFlags.n;
			vs: condEx = heldFlags.v;
			vc: condEx = !heldFlags.v;
			hi: condEx = heldFlags.c && !heldFlags.z;
			ls: condEx = !heldFlags.c || heldFlags.z;
			ge: condEx = signedGe;
			lt: condEx = !signedGe;
			gt: condEx = !heldFlags.z && signedGe;
			le: condEx = heldFlags.z || !signedGe;
			al: condEx = 1'b1;
			default: condEx = 1'b0; // 1111 never executes
		endcase
	end

	assign pcWrite = (pcSrcRequest && condHeld) || nextPc;
	assign regWrite = regWriteRequest && condHeld;
	assign memWrite = memWriteRequest && condHeld;

	// Register write-back and stores live in different states
	writesExclusive: assert property (@(posedge clk) disable iff (reset)
		!(regWrite && memWrite))
		else $error("Register write and memory write in the same cycle");
endmodule

// File: design/armCore.sv
// Core top level with the controller pieces, the datapath and the single memory port
`timescale 1ns/100ps
module armCore
	import armPkg::*;
#(
	parameter word_t resetAddress = '0
) (
	input logic clk,
	input logic reset,
	output memReq_t memReq,
	input word_t readData
);
	instr_u instr;
	flags_t aluFlags;
	dpCtrl_t dpDecode;
	dpCtrl_t dpCtrl;
	logic [1:0] flagWrite;
	logic pcSrcRequest;
	logic regWriteRequest;
	logic memWriteRequest;
	logic nextPc;
	logic pcWrite;
	logic regWrite;
	logic memWrite;
	word_t adr;
	word_t writeData;

	instrDecoder decoder (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.dpDecode(dpDecode),
		.flagWrite(flagWrite),
		.pcSrcRequest(pcSrcRequest),
		.regWriteRequest(regWriteRequest),
		.memWriteRequest(memWriteRequest),
		.nextPc(nextPc)
	);

	condLogic cond (
		.clk(clk),
		.reset(reset),
		.cond(instr.dataProcView.cond),
		.aluFlags(aluFlags),
		.flagWrite(flagWrite),
		.pcSrcRequest(pcSrcRequest),
		.regWriteRequest(regWriteRequest),
		.memWriteRequest(memWriteRequest),
		.nextPc(nextPc),
		.pcWrite(pcWrite),
		.regWrite(regWrite),
		.memWrite(memWrite)
	);

	// Gated enables replace the decoder's placeholders
	always_comb begin
		dpCtrl = dpDecode;
		dpCtrl.pcWrite = pcWrite;
		dpCtrl.regWrite = regWrite;
	end

	datapath #(
		.resetAddress(resetAddress)
	) dp (
		.clk(clk),
		.reset(reset),
		.ctrl(dpCtrl),
		.readData(readData),
		.instr(instr),
		.aluFlags(aluFlags),
		.adr(adr),
		.writeData(writeData)
	);

	assign memReq = '{adr: adr, writeData: writeData, write: memWrite};
endmodule

// File: verification/armCoreTb.sv
// Clock, reset, memory model, test file parsing, store checks and summary line
`timescale 1ns/100ps
module armCoreTb
	import armPkg::*;
();
	localparam int memWords = 64;
	localparam int halfPeriod = 20;
	localparam int resetCycles = 8;
	localparam int cycleLimit = 2000;
	localparam int settleCycles = 100;
	localparam word_t resetAdr = 32'h0000_0000;
	localparam testFile = "verification/programTests.hex";

	logic clk;
	logic reset;
	word_t readData;
	memReq_t memReq;
	word_t mem [0:memWords-1];
	word_t expAdr [$];
	word_t expData [$];
	int valueErrors = 0;
	int otherErrors = 0;
	int storeCount = 0;
	int storesExpected = 0;

	armCore #(
		.resetAddress(resetAdr)
	) uut (
		.clk(clk),
		.reset(reset),
		.memReq(memReq),
		.readData(readData)
	);

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	// Stores land at the rising edge
	always @(posedge clk) begin
		if (memReq.write === 1'b1) begin
			mem[memReq.adr[7:2]] <= memReq.writeData;
			storeCount++;
		end
	end

	always @(negedge clk)
		readData <= mem[memReq.adr[7:2]]; // Word at adr, one cycle early enough

	task automatic reportMismatch(input string name, input word_t got, input word_t exp);
		$display("error at time %0t: %s is %h, expected %h", $time, name, got, exp);
		valueErrors++;
	endtask

	// Fills memory, then reads program words and expected stores from the test file
	task automatic loadTests();
		int fd;
		int fields;
		int progIndex;
		int i;
		string line;
		string tag;
		word_t words [4];
		progIndex = 0;
		for (i = 0; i < memWords; i++)
			mem[i] = 32'hA5A5_0000 | word_t'(i << 2); // Unique per address
		fd = $fopen(testFile, "r");
		if (fd == 0) begin
			$display("Could not open the test file %s", testFile);
			otherErrors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				tag = "";
				fields = $sscanf(line, "%s %h %h %h %h", tag, words[0], words[1], words[2],
					words[3]);
				if (tag == "p") begin
					for (i = 1; i < fields; i++) begin
						if (progIndex < memWords)
							mem[progIndex] = words[i-1];
						progIndex++;
					end
				end else if (tag == "s" && fields == 3) begin
					expAdr.push_back(words[0]);
					expData.push_back(words[1]);
				end
			end
			$fclose(fd);
		end
		if (progIndex > memWords) begin
			$display("Program has %0d words but memory holds only %0d", progIndex, memWords);
			otherErrors++;
		end
		storesExpected = expAdr.size();
		if (storesExpected == 0) begin
			$display("No expected stores were found in the test file");
			otherErrors++;
		end
	endtask

	// Returns at the edge where write is high, or gives up
	task automatic awaitStore(output logic seen);
		int cycles;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < cycleLimit) begin
			@(posedge clk);
			cycles++;
			seen = (memReq.write === 1'b1);
		end
	endtask

	task automatic checkStore(input word_t adrExp, input word_t dataExp);
		assert (memReq.adr === adrExp)
			else reportMismatch("adr", memReq.adr, adrExp);
		assert (memReq.writeData === dataExp)
			else reportMismatch("writeData", memReq.writeData, dataExp);
	endtask

	initial begin
		logic seen;
		logic timedOut;
		reset = 1'b1;
		readData = '0;
		timedOut = 1'b0;
		loadTests();

		repeat (resetCycles) begin
			@(posedge clk);
			assert (memReq.write === 1'b0)
				else reportMismatch("write", word_t'(memReq.write), '0);
		end
		@(negedge clk);
		reset = 1'b0;
		@(posedge clk);
		assert (memReq.adr === resetAdr) // First fetch
			else reportMismatch("adr", memReq.adr, resetAdr);

		while (expAdr.size() > 0 && !timedOut) begin
			awaitStore(seen);
			if (seen)
				checkStore(expAdr.pop_front(), expData.pop_front());
			else begin
				$display("Timed out after %0d cycles waiting for the store to address %h",
					cycleLimit, expAdr[0]);
				otherErrors++;
				timedOut = 1'b1;
			end
		end

		// Program ends in a branch to itself, so any later store is a stray one
		if (!timedOut) begin
			repeat (settleCycles) @(posedge clk);
			assert (storeCount == storesExpected)
				else begin
					$display("Saw %0d stores but expected %0d", storeCount, storesExpected);
					otherErrors++;
				end
		end

		$display("Summary: %0d value errors, %0d other errors", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end
endmodule

// File: verilog.f
design/armPkg.sv
design/alu.sv
design/regFile.sv
design/datapath.sv
design/mainFsm.sv
design/instrDecoder.sv
design/condLogic.sv
design/armCore.sv
verification/armCoreTb.sv

// File: verification/programTests.hex
# p: up to four program words in hex, placed at consecutive word addresses from 0
# s: expected store byte address and data in hex, in the order the stores happen
p e2000000 e28010c0 e280205a e28030f3   # 00 R0 = 0, R1 = 0xc0, R2 = 0x5a, R3 = 0xf3
p e5812000 e0824003 e5814004            # 10 store ADD imm, ADD reg
p e2435010 e5815008 e0426003 e581600c   # 1c SUB imm and reg
p e203703c e5817010 e0067003 e5817014   # 2c AND imm and reg
p e3828081 e5818018 e1868002 e581801c   # 3c ORR imm and reg
p e22390ff e5819020 e0269004 e5819024   # 4c EOR imm and reg
p e052a002 0280b001 1280b007 e581b028   # 5c SUBS sets Z, ADDEQ runs, ADDNE skipped
p e213c000 2280c022 1581b030 e581c02c   # 6c ANDS keeps C, ADDCS runs, STRNE skipped
p e5816034 e590d0f4 e581d038            # 7c store, load back at 0xf4, store again
p e280a005 e20cc000 e28cc003 e25aa001   # 88 five passes adding three each
p 1afffffc e581c03c                     # 98 BNE back to 0x90, store total
p ea000000 e5812000 e28f7000 e5817030   # a0 B over a store, then ADD from R15
p e0080396 e5818034 eafffffe            # b0 MUL, store, branch to itself
s 000000c0 0000005a   # ADD imm
s 000000c4 0000014d   # ADD reg
s 000000c8 000000e3   # SUB imm
s 000000cc ffffff67   # SUB reg
s 000000d0 00000030   # AND imm
s 000000d4 00000063   # AND reg
s 000000d8 000000db   # ORR imm
s 000000dc ffffff7f   # ORR reg
s 000000e0 0000000c   # EOR imm
s 000000e4 fffffe2a   # EOR reg
s 000000e8 00000001   # ADDEQ result, ADDNE had no effect
s 000000ec 00000022   # ADDCS after ANDS
s 000000f4 ffffff67   # value for the load
s 000000f8 ffffff67   # loaded value
s 000000fc 0000000f   # loop total
s 000000f0 000000b0   # R15 read at 0xa8
s 000000f4 ffff6ec5   # MUL low word
